// ==== design/dzcpu_defs.svh ====
`ifndef DZCPU_DEFS_SVH
`define DZCPU_DEFS_SVH

// Datapath widths
`define DATA_W 8
`define ADDR_W 16
`define UPC_W 6
`define UOP_W 16

`define PC_RESET 16'h0000
`define FLAGS_RESET 8'hB0 // Z, H and C set

`define FLAG_Z 7
`define FLAG_N 6
`define FLAG_H 5
`define FLAG_C 4

// Micro-op layout {cmd, eof, ipc, 2'b00, operand}
`define UOP_CMD_MSB 15
`define UOP_CMD_LSB 11
`define UOP_EOF_MSB 10
`define UOP_EOF_LSB 8
`define UOP_IPC 7
`define UOP_OPR_MSB 4
`define UOP_OPR_LSB 0

// Register write-back source
`define RES_MEM 2'd0
`define RES_ALU 2'd1
`define RES_REG 2'd2

// Flow entry points in the microcode ROM
`define FLOW_NOP 6'd0
`define FLOW_LDRN 6'd1
`define FLOW_ALU 6'd4
`define FLOW_LDHLA 6'd5
`define FLOW_LDAHL 6'd8
`define FLOW_JP 6'd11
`define FLOW_JPNZ 6'd15
`define FLOW_JPZ 6'd20
`define FLOW_JPNC 6'd25
`define FLOW_JPC 6'd30

`endif

// ==== design/dzcpuPkg.sv ====
`default_nettype none

package dzcpuPkg;

  typedef enum logic [1:0] {
    afterReset,
    startFlow,
    runFlow,
    endFlow
  } flowState;

  typedef enum logic [4:0] {
    nop,
    sma,    // Set memory address, request read
    srm,    // Store read data into a register
    smw,    // Memory write
    aluOp,  // Move or ALU op of the latched opcode
    spc     // Load PC from a register pair
  } uopCmd;

  typedef enum logic [2:0] {
    eofNone,
    eofAlways,
    eofIfC,
    eofIfNc,
    eofIfZ,
    eofIfNz
  } eofCond;

  // Low eight follow the opcode register field
  typedef enum logic [4:0] {
    b, c, d, e, h, l, hl, a,
    pc,
    x8,
    y8,
    xy
  } regSel;

endpackage

`default_nettype wire

// ==== design/microcodeRom.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module microcodeRom import dzcpuPkg::*;
(
  input  logic [`UPC_W-1:0] upc,
  output logic [`UOP_W-1:0] uop
);

  function automatic logic [`UOP_W-1:0] mkUop(uopCmd cmd, eofCond cond, logic ipc, regSel opr);
    logic [`UOP_W-1:0] word;
    word = '0;
    word[`UOP_CMD_MSB:`UOP_CMD_LSB] = cmd;
    word[`UOP_EOF_MSB:`UOP_EOF_LSB] = cond;
    word[`UOP_IPC]                  = ipc;
    word[`UOP_OPR_MSB:`UOP_OPR_LSB] = opr;
    return word;
  endfunction

  // Every flow leaves the address select on pc
  always_comb
  begin
    case (upc)
      `FLOW_NOP:          uop = mkUop(sma, eofAlways, 1'b1, pc);
      `FLOW_LDRN:         uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_LDRN + 6'd1:  uop = mkUop(srm, eofNone, 1'b0, x8);      // Immediate
      `FLOW_LDRN + 6'd2:  uop = mkUop(aluOp, eofAlways, 1'b1, x8);
      `FLOW_ALU:          uop = mkUop(aluOp, eofAlways, 1'b1, a);
      `FLOW_LDHLA:        uop = mkUop(sma, eofNone, 1'b0, hl);
      `FLOW_LDHLA + 6'd1: uop = mkUop(smw, eofNone, 1'b0, a);
      `FLOW_LDHLA + 6'd2: uop = mkUop(sma, eofAlways, 1'b1, pc);
      `FLOW_LDAHL:        uop = mkUop(sma, eofNone, 1'b0, hl);
      `FLOW_LDAHL + 6'd1: uop = mkUop(srm, eofNone, 1'b0, a);
      `FLOW_LDAHL + 6'd2: uop = mkUop(sma, eofAlways, 1'b1, pc);
      // JP nn, low byte first
      `FLOW_JP:           uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_JP + 6'd1:    uop = mkUop(srm, eofNone, 1'b1, y8);
      `FLOW_JP + 6'd2:    uop = mkUop(srm, eofNone, 1'b1, x8);
      `FLOW_JP + 6'd3:    uop = mkUop(spc, eofAlways, 1'b0, xy);
      // Conditional jumps end early on the inverse condition
      `FLOW_JPNZ:         uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_JPNZ + 6'd1:  uop = mkUop(srm, eofNone, 1'b1, y8);
      `FLOW_JPNZ + 6'd2:  uop = mkUop(srm, eofNone, 1'b1, x8);
      `FLOW_JPNZ + 6'd3:  uop = mkUop(nop, eofIfZ, 1'b0, xy);
      `FLOW_JPNZ + 6'd4:  uop = mkUop(spc, eofAlways, 1'b0, xy);
      `FLOW_JPZ:          uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_JPZ + 6'd1:   uop = mkUop(srm, eofNone, 1'b1, y8);
      `FLOW_JPZ + 6'd2:   uop = mkUop(srm, eofNone, 1'b1, x8);
      `FLOW_JPZ + 6'd3:   uop = mkUop(nop, eofIfNz, 1'b0, xy);
      `FLOW_JPZ + 6'd4:   uop = mkUop(spc, eofAlways, 1'b0, xy);
      `FLOW_JPNC:         uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_JPNC + 6'd1:  uop = mkUop(srm, eofNone, 1'b1, y8);
      `FLOW_JPNC + 6'd2:  uop = mkUop(srm, eofNone, 1'b1, x8);
      `FLOW_JPNC + 6'd3:  uop = mkUop(nop, eofIfC, 1'b0, xy);
      `FLOW_JPNC + 6'd4:  uop = mkUop(spc, eofAlways, 1'b0, xy);
      `FLOW_JPC:          uop = mkUop(sma, eofNone, 1'b1, pc);
      `FLOW_JPC + 6'd1:   uop = mkUop(srm, eofNone, 1'b1, y8);
      `FLOW_JPC + 6'd2:   uop = mkUop(srm, eofNone, 1'b1, x8);
      `FLOW_JPC + 6'd3:   uop = mkUop(nop, eofIfNc, 1'b0, xy);
      `FLOW_JPC + 6'd4:   uop = mkUop(spc, eofAlways, 1'b0, xy);
      default:            uop = mkUop(nop, eofAlways, 1'b0, pc); // Stray entry ends the flow
    endcase
  end

endmodule

`default_nettype wire

// ==== design/flowSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module flowSequencer import dzcpuPkg::*;
(
  input  logic               iClock,
  input  logic               rst,
  input  logic [`DATA_W-1:0] iMCUData,
  input  logic               flagZ,
  input  logic               flagC,
  output logic [`UOP_W-1:0]  uop,
  output logic               flowEnable,
  output logic [`DATA_W-1:0] insn,
  output logic               eof
);

  flowState           state;
  flowState           nextState;
  logic [`UPC_W-1:0]  upc;
  logic [`UPC_W-1:0]  flowStart;
  logic               eofHit;

  microcodeRom romI (.upc(upc), .uop(uop));

  // ----------------------------------------------------------
  // Opcode to flow entry
  always_comb
  begin
    casez (iMCUData)
      8'h77:      flowStart = `FLOW_LDHLA;
      8'h7E:      flowStart = `FLOW_LDAHL;
      8'b01??????: flowStart = (iMCUData[5:3] != 3'b110 && iMCUData[2:0] != 3'b110) ?
                               `FLOW_ALU : `FLOW_NOP;
      8'b00???110: flowStart = (iMCUData[5:3] != 3'b110) ? `FLOW_LDRN : `FLOW_NOP;
      8'b10??????: flowStart = (iMCUData[2:0] != 3'b110 &&
                                iMCUData[5:3] inside {3'b000, 3'b010, 3'b100, 3'b101, 3'b110}) ?
                               `FLOW_ALU : `FLOW_NOP; // No ADC, SBC, CP
      8'hC3:      flowStart = `FLOW_JP;
      8'hC2:      flowStart = `FLOW_JPNZ;
      8'hCA:      flowStart = `FLOW_JPZ;
      8'hD2:      flowStart = `FLOW_JPNC;
      8'hDA:      flowStart = `FLOW_JPC;
      default:    flowStart = `FLOW_NOP;
    endcase
  end

  always_comb
  begin
    case (eofCond'(uop[`UOP_EOF_MSB:`UOP_EOF_LSB]))
      eofAlways: eofHit = 1'b1;
      eofIfC:    eofHit = flagC;
      eofIfNc:   eofHit = ~flagC;
      eofIfZ:    eofHit = flagZ;
      eofIfNz:   eofHit = ~flagZ;
      default:   eofHit = 1'b0;
    endcase
  end

  assign flowEnable = (state == runFlow);
  assign eof        = flowEnable & eofHit;

  // ----------------------------------------------------------
  // Flow FSM
  always_comb
  begin
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    nextState = eof ? endFlow : runFlow;
      default:    nextState = startFlow;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state <= afterReset;
      upc   <= '0;
      insn  <= '0;
    end
    else
    begin
      state <= nextState;
      if (state == startFlow)
      begin
        upc  <= flowStart;
        insn <= iMCUData; // Opcode at current PC
      end
      else if (flowEnable)
        upc <= upc + 1'b1;
    end
  end

  runFromStart: assert property (@(posedge iClock) disable iff (rst)
    (state == runFlow && $past(state) != runFlow) |-> $past(state) == startFlow)
    else $error("runFlow entered without an opcode fetch");

endmodule

`default_nettype wire

// ==== design/uopDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module uopDecoder import dzcpuPkg::*;
(
  input  logic [`UOP_W-1:0]  uop,
  input  logic [`DATA_W-1:0] insn,
  input  logic               flowEnable,
  output regSel              regRead,
  output regSel              regWrite,
  output logic               regWe,
  output logic [1:0]         resultSel,
  output logic               pcInc,
  output logic               pcLoad,
  output logic               addrLoad,
  output logic               readRequest,
  output logic               memWe
);

  uopCmd cmd;
  regSel operand;
  logic  isArith;

  assign cmd     = uopCmd'(uop[`UOP_CMD_MSB:`UOP_CMD_LSB]);
  assign operand = regSel'(uop[`UOP_OPR_MSB:`UOP_OPR_LSB]);
  assign isArith = (insn[7:6] == 2'b10);

  always_comb
  begin
    regRead     = operand;
    regWrite    = operand;
    regWe       = 1'b0;
    resultSel   = `RES_MEM;
    pcInc       = flowEnable & uop[`UOP_IPC];
    pcLoad      = 1'b0;
    addrLoad    = 1'b0;
    readRequest = 1'b0;
    memWe       = 1'b0;
    case (cmd)
      sma:
      begin
        addrLoad    = flowEnable;
        readRequest = flowEnable;
      end
      srm:     regWe = flowEnable;
      smw:     memWe = flowEnable;
      aluOp:
      begin
        // Field 6 means the byte fetched into x8
        regRead   = (insn[2:0] == 3'b110) ? x8 : regSel'({2'b00, insn[2:0]});
        regWrite  = isArith ? a : regSel'({2'b00, insn[5:3]});
        regWe     = flowEnable;
        resultSel = isArith ? `RES_ALU : `RES_REG;
      end
      spc:     pcLoad = flowEnable;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module registerFile import dzcpuPkg::*;
(
  input  logic               iClock,
  input  logic               rst,
  input  regSel              regRead,
  input  regSel              regWrite,
  input  logic               regWe,
  input  logic [`DATA_W-1:0] writeData,
  input  logic               pcInc,
  input  logic               pcLoad,
  input  logic               addrLoad,
  input  logic               readRequest,
  input  logic               memWe,
  output logic [`DATA_W-1:0] regData,
  output logic [`DATA_W-1:0] aData,
  output logic [`ADDR_W-1:0] addr,
  output logic [`DATA_W-1:0] memData,
  output logic               readRequestOut,
  output logic               memWeOut
);

  logic [`DATA_W-1:0] bReg, cReg, dReg, eReg, hReg, lReg, aReg, x8Reg, y8Reg;
  logic [`ADDR_W-1:0] pcReg;
  logic [`ADDR_W-1:0] pcSource;
  regSel              addrSel;
  logic               readReqReg;

  function automatic logic [`DATA_W-1:0] byteOf(regSel sel);
    case (sel)
      b:       return bReg;
      c:       return cReg;
      d:       return dReg;
      e:       return eReg;
      h:       return hReg;
      l:       return lReg;
      hl:      return lReg;
      a:       return aReg;
      pc:      return pcReg[`DATA_W-1:0];
      x8:      return x8Reg;
      y8:      return y8Reg;
      xy:      return y8Reg;
      default: return '0;
    endcase
  endfunction

  function automatic logic [`ADDR_W-1:0] pairOf(regSel sel);
    case (sel)
      hl:      return {hReg, lReg};
      xy:      return {x8Reg, y8Reg}; // Jump target
      pc:      return pcReg;
      default: return {{(`ADDR_W-`DATA_W){1'b0}}, byteOf(sel)};
    endcase
  endfunction

  always_comb
  begin
    regData  = byteOf(regRead);
    pcSource = pairOf(regRead);
    addr     = pairOf(addrSel);
  end

  assign aData          = aReg;
  assign memData        = regData;
  assign memWeOut       = memWe;
  assign readRequestOut = readReqReg & ~memWe;

  // ----------------------------------------------------------
  always_ff @(posedge iClock)
  begin
    if (regWe)
    begin
      case (regWrite)
        b:       bReg <= writeData;
        c:       cReg <= writeData;
        d:       dReg <= writeData;
        e:       eReg <= writeData;
        h:       hReg <= writeData;
        l:       lReg <= writeData;
        a:       aReg <= writeData;
        x8:      x8Reg <= writeData;
        y8:      y8Reg <= writeData;
        default: ;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      pcReg      <= `PC_RESET;
      addrSel    <= pc;
      readReqReg <= 1'b0;
    end
    else
    begin
      if (pcLoad)
        pcReg <= pcSource;
      else if (pcInc)
        pcReg <= pcReg + 1'b1;
      if (addrLoad)
        addrSel <= regRead;
      if (!memWe)
        readReqReg <= readRequest; // Held across a write
    end
  end

  pcOneSource: assert property (@(posedge iClock) disable iff (rst) !(pcLoad && pcInc))
    else $error("PC load and increment in the same micro-op");

endmodule

`default_nettype wire

// ==== design/z80Alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module z80Alu
(
  input  logic               iClock,
  input  logic               rst,
  input  logic [`DATA_W-1:0] insn,
  input  logic [`DATA_W-1:0] regData,
  input  logic [`DATA_W-1:0] aData,
  input  logic               flowEnable,
  input  logic               aluUpdate,
  output logic [`DATA_W-1:0] aluResult,
  output logic               flagZ,
  output logic               flagC
);

  logic [`DATA_W-1:0] flags;
  logic [`DATA_W-1:0] flagsNext;
  logic [`DATA_W:0]   sum;
  logic [`DATA_W:0]   diff;
  logic [4:0]         halfSum;
  logic               halfBorrow;
  logic               isArith;

  assign sum        = {1'b0, aData} + {1'b0, regData};
  assign diff       = {1'b0, aData} - {1'b0, regData};
  assign halfSum    = {1'b0, aData[3:0]} + {1'b0, regData[3:0]};
  assign halfBorrow = (aData[3:0] < regData[3:0]);

  always_comb
  begin
    aluResult = regData; // Moves pass the operand
    isArith   = (insn[7:6] == 2'b10);
    flagsNext = '0;
    if (isArith)
    begin
      case (insn[5:3])
        3'b000:
        begin
          aluResult          = sum[`DATA_W-1:0];
          flagsNext[`FLAG_H] = halfSum[4];
          flagsNext[`FLAG_C] = sum[`DATA_W];
        end
        3'b010:
        begin
          aluResult          = diff[`DATA_W-1:0];
          flagsNext[`FLAG_N] = 1'b1;
          flagsNext[`FLAG_H] = halfBorrow;
          flagsNext[`FLAG_C] = diff[`DATA_W]; // Borrow
        end
        3'b100:
        begin
          aluResult          = aData & regData;
          flagsNext[`FLAG_H] = 1'b1;
        end
        3'b101:  aluResult = aData ^ regData;
        3'b110:  aluResult = aData | regData;
        default: isArith = 1'b0;
      endcase
    end
    flagsNext[`FLAG_Z] = (aluResult == '0);
  end

  always_ff @(posedge iClock)
  begin
    if (rst)
      flags <= `FLAGS_RESET;
    else if (flowEnable && aluUpdate && isArith)
      flags <= flagsNext;
  end

  assign flagZ = flags[`FLAG_Z];
  assign flagC = flags[`FLAG_C];

endmodule

`default_nettype wire

// ==== design/dzcpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dzcpu_defs.svh"

module dzcpuTop import dzcpuPkg::*;
(
  input  logic               iClock,
  input  logic               rst,
  input  logic [`DATA_W-1:0] iMCUData,
  output logic [`DATA_W-1:0] oMCUData,
  output logic [`ADDR_W-1:0] oMCUAddr,
  output logic               oMcuReadRequest,
  output logic               oMCUwe,
  output logic [`DATA_W-1:0] oCurrentZ80Insn,
  output logic               oEof,
  output logic               oBranchTaken
);

  logic [`UOP_W-1:0]  uop;
  logic               flowEnable;
  logic [`DATA_W-1:0] insn;
  logic               flagZ;
  logic               flagC;
  regSel              regRead;
  regSel              regWrite;
  logic               regWe;
  logic [1:0]         resultSel;
  logic               pcInc;
  logic               pcLoad;
  logic               addrLoad;
  logic               readRequest;
  logic               memWe;
  logic [`DATA_W-1:0] regData;
  logic [`DATA_W-1:0] aData;
  logic [`DATA_W-1:0] aluResult;
  logic [`DATA_W-1:0] writeData;
  logic               aluUpdate;

  // Write-back source
  assign writeData = (resultSel == `RES_MEM) ? iMCUData :
                     (resultSel == `RES_ALU) ? aluResult : regData;
  assign aluUpdate = regWe && (resultSel == `RES_ALU);

  assign oCurrentZ80Insn = insn;
  assign oBranchTaken    = pcLoad;

  flowSequencer seqI (.*, .eof(oEof));

  uopDecoder decI (.*);

  registerFile regsI (
    .*,
    .addr           (oMCUAddr),
    .memData        (oMCUData),
    .readRequestOut (oMcuReadRequest),
    .memWeOut       (oMCUwe)
  );

  z80Alu aluI (.*);

endmodule

`default_nettype wire

// ==== sim/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock
(
  output logic clock,
  output logic porRst
);

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock; // 40 ns period
  end

  // Power-on reset for 8 cycles
  initial
  begin
    porRst <= 1'b1;
    repeat (8) @(posedge clock);
    porRst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/tbChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbChecker
(
  input  logic        clock,
  input  logic        rst,
  input  logic [15:0] addr,
  input  logic [7:0]  data,
  input  logic        we,
  input  logic        readReq,
  input  logic        eof,
  input  logic        branchTaken,
  input  logic [7:0]  insn,
  input  logic [15:0] expAddr,
  input  logic [7:0]  expData,
  input  int          expBranches,
  input  logic        rowDone,
  output int          writeCount,
  output int          errorCount
);

  int   branchCount;
  logic prevRst;
  logic firstDone;

  initial
  begin
    writeCount  = 0;
    errorCount  = 0;
    branchCount = 0;
    prevRst     = 1'b1;
    firstDone   = 1'b0;
  end

  // Sampled mid-cycle where DUT outputs are settled
  always @(negedge clock)
  begin
    if (rowDone && branchCount != expBranches)
    begin
      $display("MISMATCH oBranchTaken count: got %h expected %h", branchCount, expBranches);
      errorCount++;
    end
    if (rst)
    begin
      if (prevRst && (we || readReq || eof || branchTaken))
      begin
        $display("Memory or flow outputs active while reset is held");
        errorCount++;
      end
      branchCount = 0;
      firstDone   = 1'b0;
    end
    else
    begin
      if (prevRst && addr != 16'h0000)
      begin
        $display("MISMATCH oMCUAddr after reset: got %h expected %h", addr, 16'h0000);
        errorCount++;
      end
      if (we)
      begin
        writeCount++;
        if (!firstDone)
        begin
          $display("Memory write seen before the first instruction ended");
          errorCount++;
        end
        if (addr != expAddr)
        begin
          $display("MISMATCH oMCUAddr: got %h expected %h", addr, expAddr);
          errorCount++;
        end
        if (data != expData)
        begin
          $display("MISMATCH oMCUData: got %h expected %h", data, expData);
          errorCount++;
        end
        if (insn != 8'h77) // Only LD (HL),A stores
        begin
          $display("MISMATCH oCurrentZ80Insn: got %h expected %h", insn, 8'h77);
          errorCount++;
        end
      end
      if (branchTaken)
        branchCount++;
      if (eof)
        firstDone = 1'b1;
    end
    prevRst = rst;
  end

endmodule

`default_nettype wire

// ==== sim/tbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbTop;

  localparam int         NUM_ROWS    = 21;
  localparam int         MAX_CYCLES  = 400;
  localparam logic [7:0] RESET_FLAGS = 8'hB0; // Z=1 N=0 H=1 C=1

  logic        clock;
  logic        porRst;
  logic        rowRst;
  logic        rst;
  logic [7:0]  memData;
  logic [7:0]  writeData;
  logic [15:0] memAddr;
  logic        readReq;
  logic        memWe;
  logic [7:0]  insn;
  logic        eof;
  logic        branchTaken;
  logic [15:0] expAddr;
  logic [7:0]  expData;
  int          expBranches;
  logic        rowDone;
  int          writeCount;
  int          errorCount;
  int          timeouts;
  int          seed;

  logic [7:0]  mem [0:65535];
  logic [7:0]  progTable [NUM_ROWS][16];
  logic [15:0] addrTable [NUM_ROWS];
  logic [7:0]  dataTable [NUM_ROWS];
  int          branchTable [NUM_ROWS];

  assign rst     = porRst | rowRst;
  assign memData = mem[memAddr]; // Combinational read

  always @(posedge clock)
  begin
    if (memWe)
      mem[memAddr] <= writeData;
  end

  tbClock clockGen (.clock(clock), .porRst(porRst));

  dzcpuTop dut_i (
    .iClock          (clock),
    .rst             (rst),
    .iMCUData        (memData),
    .oMCUData        (writeData),
    .oMCUAddr        (memAddr),
    .oMcuReadRequest (readReq),
    .oMCUwe          (memWe),
    .oCurrentZ80Insn (insn),
    .oEof            (eof),
    .oBranchTaken    (branchTaken)
  );

  tbChecker checkerI (
    .clock(clock), .rst(rst), .addr(memAddr), .data(writeData), .we(memWe),
    .readReq(readReq), .eof(eof), .branchTaken(branchTaken), .insn(insn),
    .expAddr(expAddr), .expData(expData), .expBranches(expBranches), .rowDone(rowDone),
    .writeCount(writeCount), .errorCount(errorCount)
  );

  // ----------------------------------------------------------
  // Reference model of the instruction rules
  function automatic logic [7:0] aluModel(input logic [2:0] opField, input logic [7:0] x,
                                          input logic [7:0] y);
    case (opField)
      3'b000:  return x + y;
      3'b010:  return x - y;
      3'b100:  return x & y;
      3'b101:  return x ^ y;
      default: return x | y;
    endcase
  endfunction

  function automatic logic carryModel(input logic [2:0] opField, input logic [7:0] x,
                                      input logic [7:0] y);
    case (opField)
      3'b000:  return ({1'b0, x} + {1'b0, y}) > 9'h0FF;
      3'b010:  return y > x; // Borrow
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic condTaken(input logic [7:0] opcode, input logic z, input logic cy);
    case (opcode)
      8'hC2:   return !z;
      8'hCA:   return z;
      8'hD2:   return !cy;
      8'hDA:   return cy;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [2:0] opFieldOf(input int idx);
    case (idx)
      0:       return 3'b000; // ADD
      1:       return 3'b010; // SUB
      2:       return 3'b100; // AND
      3:       return 3'b101; // XOR
      default: return 3'b110; // OR
    endcase
  endfunction

  // ----------------------------------------------------------
  // Program table, byte 0 in the top bits
  task automatic putRow(input int row, input logic [127:0] bytes, input logic [15:0] addr,
                        input logic [7:0] data, input int branches);
    int i;
    for (i = 0; i < 16; i++)
      progTable[row][i] = bytes[127 - 8 * i -: 8];
    addrTable[row]   = addr;
    dataTable[row]   = data;
    branchTable[row] = branches;
  endtask

  // LD A,x  LD r,y  op A,r  LD D,A  LD A,D  LD H,C2  LD L,row  LD (HL),A
  task automatic aluRow(input int row, input logic [2:0] opField, input logic [1:0] src,
                        input logic [7:0] x, input logic [7:0] y);
    putRow(row, {8'h3E, x, 3'b000, src, 3'b110, y, 2'b10, opField, 1'b0, src,
                 8'h57, 8'h7A, 8'h26, 8'hC2, 8'h2E, row[7:0], 8'h77, 32'h0},
           {8'hC2, row[7:0]}, aluModel(opField, x, y), 0);
  endtask

  // Fall-through stores to C301, the target at 000D stores to C302
  task automatic jumpRow(input int row, input logic [2:0] opField, input logic [7:0] cc,
                         input logic [7:0] x, input logic [7:0] y);
    logic [7:0] result;
    logic       taken;
    result = aluModel(opField, x, y);
    taken  = condTaken(cc, result == 8'h00, carryModel(opField, x, y));
    putRow(row, {8'h26, 8'hC3, 8'h3E, x, 8'h06, y, 2'b10, opField, 3'b000, cc,
                 8'h0D, 8'h00, 8'h2E, 8'h01, 8'h77, 8'h2E, 8'h02, 8'h77},
           taken ? 16'hC302 : 16'hC301, result, taken ? 1 : 0);
  endtask

  task automatic buildTable();
    logic [31:0] rnd;
    logic        zTaken;
    logic        cTaken;
    int          i;
    seed = 32'he203_cd46;
    putRow(0, 128'h063C4879_26C12E23_77000000_00000000, 16'hC123, 8'h3C, 0);
    putRow(1, 128'h0E7E515A_6B26807B_77000000_00000000, 16'h807E, 8'h7E, 0);
    jumpRow(2, 3'b000, 8'hCA, 8'hF0, 8'h10);
    jumpRow(3, 3'b000, 8'hC2, 8'hF0, 8'h10);
    jumpRow(4, 3'b010, 8'hDA, 8'h03, 8'h05);
    jumpRow(5, 3'b010, 8'hD2, 8'h03, 8'h05);
    jumpRow(6, 3'b000, 8'hD2, 8'h12, 8'h34);
    jumpRow(7, 3'b000, 8'hDA, 8'h12, 8'h34);
    jumpRow(8, 3'b010, 8'hCA, 8'h05, 8'h05);
    // JP Z then JP C straight out of reset
    zTaken = condTaken(8'hCA, RESET_FLAGS[7], RESET_FLAGS[4]);
    cTaken = condTaken(8'hDA, RESET_FLAGS[7], RESET_FLAGS[4]);
    putRow(9, 128'h26C42E05_3E99CA0A_0077DA0E_00776F77,
           (zTaken && cTaken) ? 16'hC499 : 16'hC405, 8'h99, zTaken ? 1 + cTaken : 0);
    rnd = $random(seed);
    putRow(10, {96'hC30500_3EEE_26002E0F_7E26C5, 24'h2E6077, rnd[7:0]},
           16'hC560, rnd[7:0], 1);
    for (i = 0; i < 10; i++)
    begin
      rnd = $random(seed);
      aluRow(11 + i, opFieldOf(i % 5), i[1:0], rnd[7:0], rnd[15:8]);
    end
  endtask

  task automatic loadProgram(input int row);
    int i;
    for (i = 0; i < 65536; i++)
      mem[i] <= i[15:8] ^ i[7:0];
    for (i = 0; i < 16; i++)
      mem[i] <= progTable[row][i];
  endtask

  // ----------------------------------------------------------
  initial
  begin
    int row;
    int cycles;
    int startCount;
    rowRst      <= 1'b1;
    rowDone     <= 1'b0;
    expAddr     <= '0;
    expData     <= '0;
    expBranches <= 0;
    timeouts = 0;
    buildTable();
    loadProgram(0);
    cycles = 0;
    while (porRst && cycles < 20)
    begin
      @(posedge clock);
      cycles++;
    end
    if (porRst)
    begin
      $display("Power-on reset was never released");
      timeouts++;
    end
    for (row = 0; row < NUM_ROWS; row++)
    begin
      loadProgram(row);
      expAddr     <= addrTable[row];
      expData     <= dataTable[row];
      expBranches <= branchTable[row];
      rowRst      <= 1'b0;
      startCount = writeCount;
      cycles     = 0;
      while (writeCount == startCount && cycles < MAX_CYCLES)
      begin
        @(posedge clock);
        cycles++;
      end
      if (writeCount == startCount)
      begin
        $display("Row %0d: no memory write within %0d cycles", row, MAX_CYCLES);
        timeouts++;
      end
      rowDone <= 1'b1; // Branch count checked as reset starts
      rowRst  <= 1'b1;
      @(posedge clock);
      rowDone <= 1'b0;
      repeat (7) @(posedge clock);
    end
    $display("Closing counts: %0d check errors, %0d timeouts", errorCount, timeouts);
    if (errorCount == 0 && timeouts == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/dzcpuPkg.sv
design/microcodeRom.sv
design/flowSequencer.sv
design/uopDecoder.sv
design/registerFile.sv
design/z80Alu.sv
design/dzcpuTop.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f list.f -o simv \
  && ./obj_dir/simv | tee sim.log \
  || echo "Build or simulation did not complete"
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
